/* rtl/i2c_pkg.sv */
package i2c_pkg;

	////////////////////
	// transfer direction as sent in the R/W bit
	typedef enum logic {
		OP_WRITE = 1'b0,
		OP_READ  = 1'b1
	} i2c_op_e;

	////////////////////
	// bit-level master states of one SCL period each
	typedef enum logic [3:0] {
		IDLE,
		START,
		ADDR,        // 7 address bits msb first
		RW,
		ADDR_ACK,
		WRITE,
		DATA_ACK,
		READ,
		MASTER_NACK, // master releases sda after the read byte
		STOP
	} i2c_state_e;

	// command from the register block
	typedef struct packed {
		logic [6:0] dev_addr;
		i2c_op_e    op;
		logic [7:0] wdata;
	} i2c_cmd_t;

	// finished transfer valid with done
	typedef struct packed {
		logic [6:0] dev_addr;
		i2c_op_e    op;
		logic       nack;
		logic [7:0] data;    // byte sent or byte received
	} i2c_result_t;

endpackage

/* rtl/display_pkg.sv */
package display_pkg;

	typedef enum logic [1:0] {
		LS_INIT, // power-up command bytes
		LS_IDLE,
		LS_LINE  // home plus four status characters
	} lcd_state_e;

	////////////////////
	// HD44780 command bytes
	localparam logic [7:0] LCD_FUNC_SET = 8'h38; // 8 bit bus, 2 lines
	localparam logic [7:0] LCD_DISP_ON  = 8'h0C;
	localparam logic [7:0] LCD_ENTRY    = 8'h06; // increment, no shift
	localparam logic [7:0] LCD_CLEAR    = 8'h01;
	localparam logic [7:0] LCD_HOME     = 8'h02;

	// active low segments with a in bit 6 down to g in bit 0
	function automatic logic [6:0] hex_to_seg(input logic [3:0] v);
		logic [6:0] seg;
		case (v)
			4'h0: seg = 7'b0000001;
			4'h1: seg = 7'b1001111;
			4'h2: seg = 7'b0010010;
			4'h3: seg = 7'b0000110;
			4'h4: seg = 7'b1001100;
			4'h5: seg = 7'b0100100;
			4'h6: seg = 7'b0100000;
			4'h7: seg = 7'b0001111;
			4'h8: seg = 7'b0000000;
			4'h9: seg = 7'b0000100;
			4'hA: seg = 7'b0001000;
			4'hB: seg = 7'b1100000;
			4'hC: seg = 7'b0110001;
			4'hD: seg = 7'b1000010;
			4'hE: seg = 7'b0110000;
			default: seg = 7'b0111000; // F
		endcase
		return seg;
	endfunction

	function automatic logic [7:0] hex_to_ascii(input logic [3:0] v);
		if (v < 4'd10)
			return 8'h30 + {4'd0, v}; // '0'..'9'
		return 8'h37 + {4'd0, v};     // 'A'..'F'
	endfunction

endpackage

/* rtl/axil_ctrl_regs.sv */
`timescale 1ns/1ps

module axil_ctrl_regs (
	input  logic                 clk1,
	input  logic                 reset,
	// write address and data
	input  logic [3:0]           awaddr,
	input  logic                 awvalid,
	output logic                 awready,
	input  logic [31:0]          wdata,
	input  logic [3:0]           wstrb,
	input  logic                 wvalid,
	output logic                 wready,
	output logic                 bvalid,
	output logic [1:0]           bresp,
	input  logic                 bready,
	// read
	input  logic [3:0]           araddr,
	input  logic                 arvalid,
	output logic                 arready,
	output logic                 rvalid,
	output logic [31:0]          rdata,
	output logic [1:0]           rresp,
	input  logic                 rready,
	// master side
	input  logic                 busy,
	input  logic                 done,
	input  i2c_pkg::i2c_result_t result,
	output i2c_pkg::i2c_cmd_t    cmd,
	output logic                 cmd_valid
);

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	localparam logic [1:0] REG_DEV    = 2'd0;
	localparam logic [1:0] REG_WDATA  = 2'd1;
	localparam logic [1:0] REG_CMD    = 2'd2;
	localparam logic [1:0] REG_STATUS = 2'd3;

	logic [6:0] dev_reg;
	logic [7:0] wbyte_reg;
	logic       last_nack;
	logic [7:0] last_data;
	logic       wr_go;
	logic       wr_ok;
	logic       rd_go;
	logic [1:0] wr_sel;
	logic [1:0] rd_sel;

	assign awready = awvalid && wvalid && !bvalid; // address and data taken together
	assign wready  = awready;
	assign wr_go   = awready;
	assign wr_sel  = awaddr[3:2];
	assign wr_ok   = (awaddr[1:0] == 2'b00) && (wr_sel != REG_STATUS) &&
	                 !(wr_sel == REG_CMD && busy);

	assign arready = !rvalid;
	assign rd_go   = arvalid && arready;
	assign rd_sel  = araddr[3:2];

	////////////////////
	// write channel
	always_ff @(posedge clk1) begin
		if (reset) begin
			bvalid    <= 1'b0;
			cmd_valid <= 1'b0;
			dev_reg   <= '0;
			wbyte_reg <= '0;
		end else begin
			cmd_valid <= 1'b0;
			if (wr_go)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;
			if (wr_go && wr_ok && wstrb[0]) begin
				case (wr_sel)
					REG_DEV:   dev_reg   <= wdata[6:0];
					REG_WDATA: wbyte_reg <= wdata[7:0];
					REG_CMD:   cmd_valid <= 1'b1; // launch next cycle
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk1) begin
		if (wr_go) begin
			bresp        <= wr_ok ? RESP_OKAY : RESP_SLVERR;
			cmd.dev_addr <= dev_reg;
			cmd.op       <= i2c_pkg::i2c_op_e'(wdata[0]);
			cmd.wdata    <= wbyte_reg;
		end
	end

	// status from the last finished transfer
	always_ff @(posedge clk1) begin
		if (reset) begin
			last_nack <= 1'b0;
			last_data <= '0;
		end else if (done) begin
			last_nack <= result.nack;
			last_data <= result.data;
		end
	end

	////////////////////
	// read channel
	always_ff @(posedge clk1) begin
		if (reset)
			rvalid <= 1'b0;
		else if (rd_go)
			rvalid <= 1'b1;
		else if (rready)
			rvalid <= 1'b0;
	end

	always_ff @(posedge clk1) begin
		if (rd_go) begin
			rresp <= RESP_OKAY;
			rdata <= '0;
			if (araddr[1:0] != 2'b00) begin
				rresp <= RESP_SLVERR;
			end else begin
				case (rd_sel)
					REG_DEV:   rdata <= {25'd0, dev_reg};
					REG_WDATA: rdata <= {24'd0, wbyte_reg};
					REG_CMD:   rresp <= RESP_SLVERR; // write only
					default:   rdata <= {16'd0, last_data, 6'd0, last_nack, busy};
				endcase
			end
		end
	end

endmodule

/* rtl/i2c_byte_master.sv */
`timescale 1ns/1ps

module i2c_byte_master #(
	parameter int SCL_HALF = 250
) (
	input  logic                 clk1,
	input  logic                 reset,
	input  i2c_pkg::i2c_cmd_t    cmd,
	input  logic                 cmd_valid,
	input  logic                 sda_in,
	output logic                 scl,
	output logic                 sda_oe,    // 1 pulls sda low
	output logic                 busy,
	output logic                 done,
	output i2c_pkg::i2c_result_t result
);

	localparam int PW = $clog2(2 * SCL_HALF);

	// phase points inside one bit period
	localparam logic [PW-1:0] LAST     = PW'(2 * SCL_HALF - 1);
	localparam logic [PW-1:0] HALF     = PW'(SCL_HALF);
	localparam logic [PW-1:0] MID_LOW  = PW'(SCL_HALF / 2);
	localparam logic [PW-1:0] MID_HIGH = PW'(SCL_HALF + SCL_HALF / 2);

	i2c_pkg::i2c_state_e state;
	i2c_pkg::i2c_cmd_t   cur;     // command held for the whole transfer
	logic [PW-1:0]       phase;
	logic [2:0]          bit_cnt;
	logic [7:0]          data_sr;
	logic                nack;
	logic                bit_end;
	logic                tx_bit;  // 1 releases the line

	assign bit_end = (phase == LAST);

	always_comb begin
		case (state)
			i2c_pkg::ADDR:  tx_bit = cur.dev_addr[bit_cnt];
			i2c_pkg::RW:    tx_bit = (cur.op == i2c_pkg::OP_READ);
			i2c_pkg::WRITE: tx_bit = data_sr[bit_cnt];
			default:        tx_bit = 1'b1; // acks from slave, read bits, master nack
		endcase
	end

	////////////////////
	// bus pins
	always_ff @(posedge clk1) begin
		if (reset) begin
			scl    <= 1'b1;
			sda_oe <= 1'b0;
		end else begin
			case (state)
				i2c_pkg::IDLE, i2c_pkg::START: scl <= 1'b1;
				default: scl <= (phase >= HALF); // low half, then high half
			endcase
			case (state)
				i2c_pkg::IDLE:  sda_oe <= 1'b0;
				i2c_pkg::START: if (phase == HALF) sda_oe <= 1'b1; // falls under scl high
				i2c_pkg::STOP: begin
					if (phase == MID_LOW)
						sda_oe <= 1'b1;
					else if (phase == MID_HIGH)
						sda_oe <= 1'b0;  // rises under scl high
				end
				default: if (phase == MID_LOW) sda_oe <= ~tx_bit;
			endcase
		end
	end

	////////////////////
	// state machine
	always_ff @(posedge clk1) begin
		if (reset) begin
			state   <= i2c_pkg::IDLE;
			phase   <= '0;
			bit_cnt <= '0;
			nack    <= 1'b0;
			busy    <= 1'b0;
			done    <= 1'b0;
		end else begin
			done <= 1'b0;
			if (done)
				busy <= 1'b0;
			if (state == i2c_pkg::IDLE) begin
				phase <= '0;
				if (cmd_valid) begin
					busy  <= 1'b1;
					nack  <= 1'b0;
					state <= i2c_pkg::START;
				end
			end else begin
				phase <= bit_end ? '0 : phase + 1'b1;
				if (phase == MID_HIGH &&
				    (state == i2c_pkg::ADDR_ACK || state == i2c_pkg::DATA_ACK))
					nack <= sda_in; // high here means nobody answered
				if (bit_end) begin
					case (state)
						i2c_pkg::START: begin
							bit_cnt <= 3'd6;
							state   <= i2c_pkg::ADDR;
						end
						i2c_pkg::ADDR: begin
							if (bit_cnt == 3'd0)
								state <= i2c_pkg::RW;
							else
								bit_cnt <= bit_cnt - 1'b1;
						end
						i2c_pkg::RW: state <= i2c_pkg::ADDR_ACK;
						i2c_pkg::ADDR_ACK: begin
							bit_cnt <= 3'd7;
							if (nack)
								state <= i2c_pkg::STOP;
							else if (cur.op == i2c_pkg::OP_READ)
								state <= i2c_pkg::READ;
							else
								state <= i2c_pkg::WRITE;
						end
						i2c_pkg::WRITE: begin
							if (bit_cnt == 3'd0)
								state <= i2c_pkg::DATA_ACK;
							else
								bit_cnt <= bit_cnt - 1'b1;
						end
						i2c_pkg::DATA_ACK: state <= i2c_pkg::STOP;
						i2c_pkg::READ: begin
							if (bit_cnt == 3'd0)
								state <= i2c_pkg::MASTER_NACK;
							else
								bit_cnt <= bit_cnt - 1'b1;
						end
						i2c_pkg::MASTER_NACK: state <= i2c_pkg::STOP;
						default: begin  // STOP
							state <= i2c_pkg::IDLE;
							done  <= 1'b1;
						end
					endcase
				end
			end
		end
	end

	// command and data byte
	always_ff @(posedge clk1) begin
		if (state == i2c_pkg::IDLE && cmd_valid) begin
			cur     <= cmd;
			data_sr <= (cmd.op == i2c_pkg::OP_READ) ? 8'h00 : cmd.wdata;
		end else if (state == i2c_pkg::READ && phase == MID_HIGH) begin
			data_sr[bit_cnt] <= sda_in;
		end
	end

	assign result = '{dev_addr: cur.dev_addr, op: cur.op, nack: nack, data: data_sr};

endmodule

/* rtl/seg_scanner.sv */
`timescale 1ns/1ps

module seg_scanner #(
	parameter int SCAN_DIV = 50000
) (
	input  logic                 clk1,
	input  logic                 reset,
	input  logic                 done,
	input  i2c_pkg::i2c_result_t result,
	output logic [3:0]           anode,   // active low
	output logic [6:0]           cathode  // active low segments a..g
);

	localparam int DW = $clog2(SCAN_DIV + 1);

	logic [DW-1:0] pre_cnt;
	logic [1:0]    digit;
	logic [6:0]    addr_q;
	logic [7:0]    data_q;
	logic [3:0]    nib;

	// shown values stay zero until the first transfer
	always_ff @(posedge clk1) begin
		if (reset) begin
			addr_q <= '0;
			data_q <= '0;
		end else if (done) begin
			addr_q <= result.dev_addr;
			data_q <= result.data;
		end
	end

	always_ff @(posedge clk1) begin
		if (reset) begin
			pre_cnt <= '0;
			digit   <= '0;
		end else if (pre_cnt == DW'(SCAN_DIV - 1)) begin
			pre_cnt <= '0;
			digit   <= digit + 1'b1; // 0,1,2,3 and around
		end else begin
			pre_cnt <= pre_cnt + 1'b1;
		end
	end

	always_comb begin
		case (digit)
			2'd0:    nib = {1'b0, addr_q[6:4]};
			2'd1:    nib = addr_q[3:0];
			2'd2:    nib = data_q[7:4];
			default: nib = data_q[3:0];
		endcase
	end

	always_ff @(posedge clk1) begin
		if (reset) begin
			anode   <= 4'b1111; // all digits off
			cathode <= 7'b1111111;
		end else begin
			anode   <= ~(4'b0001 << digit);
			cathode <= display_pkg::hex_to_seg(nib);
		end
	end

endmodule

/* rtl/lcd_status_writer.sv */
`timescale 1ns/1ps

module lcd_status_writer #(
	parameter int LCD_TICK = 1000
) (
	input  logic                 clk1,
	input  logic                 reset,
	input  logic                 done,
	input  i2c_pkg::i2c_result_t result,
	output logic                 rs,
	output logic                 en,
	output logic [7:0]           db
);

	localparam int TW = $clog2(LCD_TICK + 1);

	display_pkg::lcd_state_e state;
	logic [TW-1:0]           tick_cnt;
	logic [2:0]              idx;        // byte within init or line
	logic                    tick_end;
	logic                    byte_end;
	logic                    pend_valid;
	i2c_pkg::i2c_result_t    pend;       // one-deep slot where the newest wins
	i2c_pkg::i2c_result_t    shown;

	assign tick_end = (tick_cnt == TW'(LCD_TICK - 1));
	assign byte_end = tick_end && en; // end of the enable pulse

	////////////////////
	// byte selection
	always_comb begin
		rs = 1'b0;
		db = 8'h00;
		case (state)
			display_pkg::LS_INIT: begin
				case (idx)
					3'd0:    db = display_pkg::LCD_FUNC_SET;
					3'd1:    db = display_pkg::LCD_DISP_ON;
					3'd2:    db = display_pkg::LCD_ENTRY;
					default: db = display_pkg::LCD_CLEAR;
				endcase
			end
			display_pkg::LS_LINE: begin
				rs = (idx != 3'd0); // characters after the home command
				case (idx)
					3'd0:    db = display_pkg::LCD_HOME;
					3'd1:    db = (shown.op == i2c_pkg::OP_READ) ? "R" : "W";
					3'd2:    db = shown.nack ? "N" : "A";
					3'd3:    db = display_pkg::hex_to_ascii(shown.data[7:4]);
					default: db = display_pkg::hex_to_ascii(shown.data[3:0]);
				endcase
			end
			default: ;
		endcase
	end

	////////////////////
	// sequencer
	always_ff @(posedge clk1) begin
		if (reset) begin
			state      <= display_pkg::LS_INIT;
			idx        <= '0;
			tick_cnt   <= '0;
			en         <= 1'b0;
			pend_valid <= 1'b0;
		end else begin
			if (state == display_pkg::LS_IDLE) begin
				tick_cnt <= '0;
				if (pend_valid) begin
					state      <= display_pkg::LS_LINE;
					idx        <= '0;
					pend_valid <= 1'b0;
				end
			end else begin
				tick_cnt <= tick_end ? '0 : tick_cnt + 1'b1;
				if (tick_end)
					en <= ~en; // setup phase, then enable phase
				if (byte_end) begin
					if ((state == display_pkg::LS_INIT && idx == 3'd3) ||
					    (state == display_pkg::LS_LINE && idx == 3'd4)) begin
						state <= display_pkg::LS_IDLE;
						idx   <= '0;
					end else begin
						idx <= idx + 1'b1;
					end
				end
			end
			if (done)
				pend_valid <= 1'b1;
		end
	end

	always_ff @(posedge clk1) begin
		if (done)
			pend <= result;
		if (state == display_pkg::LS_IDLE && pend_valid)
			shown <= pend;
	end

endmodule

/* rtl/eeprom_panel_top.sv */
`timescale 1ns/1ps

module eeprom_panel_top #(
	parameter int SCL_HALF = 250,   // 100 kHz from 50 MHz
	parameter int SCAN_DIV = 50000,
	parameter int LCD_TICK = 1000
) (
	input  logic        clk1,
	input  logic        reset,
	// host registers
	input  logic [3:0]  awaddr,
	input  logic        awvalid,
	output logic        awready,
	input  logic [31:0] wdata,
	input  logic [3:0]  wstrb,
	input  logic        wvalid,
	output logic        wready,
	output logic        bvalid,
	output logic [1:0]  bresp,
	input  logic        bready,
	input  logic [3:0]  araddr,
	input  logic        arvalid,
	output logic        arready,
	output logic        rvalid,
	output logic [31:0] rdata,
	output logic [1:0]  rresp,
	input  logic        rready,
	// i2c bus
	output logic        scl,
	output logic        sda_oe,
	input  logic        sda_in,
	// displays
	output logic [3:0]  anode,
	output logic [6:0]  cathode,
	output logic        rs,
	output logic        en,
	output logic [7:0]  db
);

	i2c_pkg::i2c_cmd_t    cmd;
	logic                 cmd_valid;
	logic                 busy;
	logic                 done;
	i2c_pkg::i2c_result_t result;

	axil_ctrl_regs i_regs (
		.clk1(clk1), .reset(reset),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bvalid(bvalid), .bresp(bresp), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rvalid(rvalid), .rdata(rdata), .rresp(rresp), .rready(rready),
		.busy(busy), .done(done), .result(result),
		.cmd(cmd), .cmd_valid(cmd_valid)
	);

	i2c_byte_master #(.SCL_HALF(SCL_HALF)) i_master (
		.clk1(clk1), .reset(reset),
		.cmd(cmd), .cmd_valid(cmd_valid), .sda_in(sda_in),
		.scl(scl), .sda_oe(sda_oe),
		.busy(busy), .done(done), .result(result)
	);

	seg_scanner #(.SCAN_DIV(SCAN_DIV)) i_seg (
		.clk1(clk1), .reset(reset), .done(done), .result(result),
		.anode(anode), .cathode(cathode)
	);

	lcd_status_writer #(.LCD_TICK(LCD_TICK)) i_lcd (
		.clk1(clk1), .reset(reset), .done(done), .result(result),
		.rs(rs), .en(en), .db(db)
	);

endmodule

/* verif/i2c_eeprom_model.sv */
`timescale 1ns/1ps

module i2c_eeprom_model #(
	parameter logic [6:0] DEV_ADDR  = 7'h50,
	parameter logic [7:0] INIT_BYTE = 8'hA5
) (
	input  logic       scl,
	input  logic       sda_oe,  // master pulls low
	output logic       sda,     // resolved open-drain line
	output logic [7:0] stored
);

	logic       pull     = 1'b0;
	logic       active   = 1'b0;
	logic       matched  = 1'b0;
	logic       is_read  = 1'b0;
	logic       scl_q    = 1'b1;
	logic       sda_q    = 1'b1;
	logic [7:0] shift    = 8'h00;
	logic [7:0] mem      = INIT_BYTE;
	int         edge_cnt = 0;

	assign sda    = !(sda_oe || pull); // wired-AND with pull-up
	assign stored = mem;

	always @(scl or sda) begin
		if (scl_q === 1'b1 && scl === 1'b1 && sda_q === 1'b1 && sda === 1'b0) begin
			active   = 1'b1; // start
			matched  = 1'b0;
			edge_cnt = 0;
			pull     = 1'b0;
		end else if (scl_q === 1'b1 && scl === 1'b1 && sda_q === 1'b0 && sda === 1'b1) begin
			active = 1'b0;   // stop
			pull   = 1'b0;
		end else if (scl_q === 1'b0 && scl === 1'b1 && active) begin
			edge_cnt = edge_cnt + 1;
			if (edge_cnt <= 8 || (edge_cnt >= 10 && edge_cnt <= 17))
				shift = {shift[6:0], sda};
			if (edge_cnt == 8) begin
				matched = (shift[7:1] == DEV_ADDR);
				is_read = shift[0];
			end
			if (edge_cnt == 17 && matched && !is_read)
				mem = shift;
		end else if (scl_q === 1'b1 && scl === 1'b0 && active) begin
			// next bit goes out while scl is low
			pull = 1'b0;
			if (matched) begin
				if (edge_cnt == 8)
					pull = 1'b1;   // address ack
				else if (is_read && edge_cnt >= 9 && edge_cnt <= 16)
					pull = !mem[16 - edge_cnt];
				else if (!is_read && edge_cnt == 17)
					pull = 1'b1;   // data ack
			end
		end
		scl_q = scl;
		sda_q = sda;
	end

endmodule

/* verif/eeprom_panel_tb.sv */
`timescale 1ns/1ps

module eeprom_panel_tb;

	localparam int SCL_HALF = 4;
	localparam int SCAN_DIV = 8;
	localparam int LCD_TICK = 2;
	localparam int MAX_WAIT = 2000;

	logic        clk1;
	logic        reset;
	logic [3:0]  awaddr;
	logic        awvalid;
	logic        awready;
	logic [31:0] wdata;
	logic [3:0]  wstrb;
	logic        wvalid;
	logic        wready;
	logic        bvalid;
	logic [1:0]  bresp;
	logic        bready;
	logic [3:0]  araddr;
	logic        arvalid;
	logic        arready;
	logic        rvalid;
	logic [31:0] rdata;
	logic [1:0]  rresp;
	logic        rready;
	logic        scl;
	logic        sda_oe;
	logic        sda_line;
	logic [3:0]  anode;
	logic [6:0]  cathode;
	logic        rs;
	logic        en;
	logic [7:0]  db;
	logic [7:0]  ee_byte;

	int          errors;
	int          tests_run;
	int          tests_failed;
	int          seed;
	logic [8:0]  lcd_q[$];  // {rs, db} per enable pulse
	int          lcd_head;
	logic        en_q;
	event        timeout_ev;
	string       timeout_what;

	eeprom_panel_top #(.SCL_HALF(SCL_HALF), .SCAN_DIV(SCAN_DIV), .LCD_TICK(LCD_TICK)) i_dut (
		.clk1(clk1), .reset(reset),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bvalid(bvalid), .bresp(bresp), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rvalid(rvalid), .rdata(rdata), .rresp(rresp), .rready(rready),
		.scl(scl), .sda_oe(sda_oe), .sda_in(sda_line),
		.anode(anode), .cathode(cathode), .rs(rs), .en(en), .db(db)
	);

	i2c_eeprom_model #(.DEV_ADDR(7'h50)) i_eeprom (
		.scl(scl), .sda_oe(sda_oe), .sda(sda_line), .stored(ee_byte)
	);

	initial begin
		clk1 = 1'b0;
		forever #10 clk1 = ~clk1;
	end

	// lcd bytes taken on each enable rise
	always @(negedge clk1) begin
		if (reset) begin
			en_q <= 1'b0;
		end else begin
			if (en && !en_q)
				lcd_q.push_back({rs, db});
			en_q <= en;
		end
	end

	// ends the run when any wait gives up
	initial begin
		@(timeout_ev);
		$display("Timeout while waiting for %s", timeout_what);
		$display("Test failures found");
		$finish;
	end

	////////////////////
	// helpers
	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic abort_timeout(input string what);
		timeout_what = what;
		-> timeout_ev;
		forever @(posedge clk1); // parks the caller until the run ends
	endtask

	task automatic report_test(input string name, input int errs_before);
		tests_run++;
		if (errors == errs_before) begin
			$display("%s: ok", name);
		end else begin
			tests_failed++;
			$display("%s: failed", name);
		end
	endtask

	function automatic logic [6:0] seg_pattern(input logic [3:0] v);
		case (v)
			4'h0: return 7'b0000001;
			4'h1: return 7'b1001111;
			4'h2: return 7'b0010010;
			4'h3: return 7'b0000110;
			4'h4: return 7'b1001100;
			4'h5: return 7'b0100100;
			4'h6: return 7'b0100000;
			4'h7: return 7'b0001111;
			4'h8: return 7'b0000000;
			4'h9: return 7'b0000100;
			4'hA: return 7'b0001000;
			4'hB: return 7'b1100000;
			4'hC: return 7'b0110001;
			4'hD: return 7'b1000010;
			4'hE: return 7'b0110000;
			default: return 7'b0111000;
		endcase
	endfunction

	function automatic logic [7:0] hex_char(input logic [3:0] v);
		string digits;
		digits = "0123456789ABCDEF";
		return digits[v];
	endfunction

	////////////////////
	// AXI4-Lite
	task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
	                          output logic [1:0] resp);
		int n;
		@(posedge clk1);
		awaddr  <= addr;
		wdata   <= data;
		wstrb   <= 4'hF;
		awvalid <= 1'b1;
		wvalid  <= 1'b1;
		n = 0;
		do begin
			@(negedge clk1);
			if (++n > MAX_WAIT) abort_timeout("awready and wready");
		end while (!(awready && wready));
		@(posedge clk1);
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		n = 0;
		do begin
			@(negedge clk1);
			if (++n > MAX_WAIT) abort_timeout("bvalid");
		end while (!bvalid);
		resp = bresp;
		@(posedge clk1);
		bready <= 1'b1;
		@(posedge clk1);
		bready <= 1'b0;
	endtask

	task automatic axil_read(input logic [3:0] addr, output logic [31:0] data,
	                         output logic [1:0] resp);
		int n;
		@(posedge clk1);
		araddr  <= addr;
		arvalid <= 1'b1;
		n = 0;
		do begin
			@(negedge clk1);
			if (++n > MAX_WAIT) abort_timeout("arready");
		end while (!arready);
		@(posedge clk1);
		arvalid <= 1'b0;
		n = 0;
		do begin
			@(negedge clk1);
			if (++n > MAX_WAIT) abort_timeout("rvalid");
		end while (!rvalid);
		data = rdata;
		resp = rresp;
		@(posedge clk1);
		rready <= 1'b1;
		@(posedge clk1);
		rready <= 1'b0;
	endtask

	// polls STATUS until busy drops
	task automatic wait_idle(output logic [31:0] status);
		logic [1:0] resp;
		int         n;
		n = 0;
		do begin
			axil_read(4'hC, status, resp);
			if (++n > MAX_WAIT) abort_timeout("busy to clear");
		end while (status[0]);
		check_val("STATUS rresp", resp, 2'b00);
	endtask

	task automatic lcd_capture(input int count);
		int n;
		n = 0;
		while (lcd_q.size() < lcd_head + count) begin
			@(negedge clk1);
			if (++n > MAX_WAIT) abort_timeout("LCD bytes");
		end
	endtask

	// waits until the LCD has been quiet a while, then drops old bytes
	task automatic lcd_settle();
		int n;
		int quiet;
		n = 0;
		quiet = 0;
		while (quiet < 4 * LCD_TICK + 2) begin
			@(negedge clk1);
			quiet = en ? 0 : quiet + 1;
			if (++n > MAX_WAIT) abort_timeout("LCD to go quiet");
		end
		lcd_head = lcd_q.size();
	endtask

	task automatic run_transfer(input logic [6:0] dev, input logic [7:0] wbyte, input logic op,
	                            output logic [31:0] status);
		logic [1:0] resp;
		axil_write(4'h0, {25'd0, dev}, resp);
		axil_write(4'h4, {24'd0, wbyte}, resp);
		axil_write(4'h8, {31'd0, op}, resp);
		check_val("CMD bresp", resp, 2'b00);
		wait_idle(status);
	endtask

	////////////////////
	// directed tests
	task automatic test_lcd_init();
		int e;
		e = errors;
		lcd_capture(4);
		check_val("lcd byte 0", lcd_q[lcd_head],     {1'b0, display_pkg::LCD_FUNC_SET});
		check_val("lcd byte 1", lcd_q[lcd_head + 1], {1'b0, display_pkg::LCD_DISP_ON});
		check_val("lcd byte 2", lcd_q[lcd_head + 2], {1'b0, display_pkg::LCD_ENTRY});
		check_val("lcd byte 3", lcd_q[lcd_head + 3], {1'b0, display_pkg::LCD_CLEAR});
		report_test("lcd init", e);
	endtask

	task automatic test_registers();
		logic [31:0] d;
		logic [31:0] st;
		logic [1:0]  r;
		int          e;
		e = errors;
		axil_write(4'h0, 32'h2A, r);
		check_val("DEV bresp", r, 2'b00);
		axil_write(4'h4, 32'h3C, r);
		check_val("WDATA bresp", r, 2'b00);
		axil_read(4'h0, d, r);
		check_val("DEV", d, 32'h2A);
		axil_read(4'h4, d, r);
		check_val("WDATA", d, 32'h3C);
		axil_write(4'hC, 32'h1, r);
		check_val("STATUS write bresp", r, 2'b10);
		axil_write(4'h6, 32'h1, r);  // not word aligned
		check_val("unmapped bresp", r, 2'b10);
		axil_read(4'h8, d, r);
		check_val("CMD rresp", r, 2'b10);
		check_val("CMD rdata", d, 32'h0);
		axil_write(4'h8, 32'h0, r);
		check_val("CMD bresp", r, 2'b00);
		axil_write(4'h8, 32'h0, r);  // master still busy
		check_val("busy CMD bresp", r, 2'b10);
		wait_idle(st);
		report_test("registers", e);
	endtask

	task automatic test_write(output logic [7:0] wbyte);
		logic [31:0] st;
		int          e;
		e = errors;
		wbyte = 8'($random(seed));
		run_transfer(7'h50, wbyte, 1'b0, st);
		check_val("STATUS nack", st[1], 1'b0);
		check_val("STATUS data", st[15:8], wbyte);
		check_val("stored byte", ee_byte, wbyte);
		report_test("write transfer", e);
	endtask

	task automatic test_read(input logic [7:0] expect_byte);
		logic [31:0] st;
		int          e;
		e = errors;
		lcd_settle();
		run_transfer(7'h50, 8'h00, 1'b1, st);
		check_val("STATUS nack", st[1], 1'b0);
		check_val("STATUS data", st[15:8], expect_byte);
		report_test("read transfer", e);
		e = errors;
		lcd_capture(5);
		check_val("lcd home", lcd_q[lcd_head],         {1'b0, display_pkg::LCD_HOME});
		check_val("lcd op", lcd_q[lcd_head + 1],       {1'b1, 8'h52}); // R
		check_val("lcd ack", lcd_q[lcd_head + 2],      {1'b1, 8'h41}); // A
		check_val("lcd hi", lcd_q[lcd_head + 3],       {1'b1, hex_char(expect_byte[7:4])});
		check_val("lcd lo", lcd_q[lcd_head + 4],       {1'b1, hex_char(expect_byte[3:0])});
		report_test("lcd status line", e);
	endtask

	task automatic test_nack(input logic [7:0] old_byte, input logic [7:0] wbyte);
		logic [31:0] st;
		int          e;
		e = errors;
		run_transfer(7'h23, wbyte, 1'b0, st);
		check_val("STATUS nack", st[1], 1'b1);
		check_val("stored byte", ee_byte, old_byte);
		report_test("address nack", e);
	endtask

	task automatic test_segments(input logic [6:0] dev, input logic [7:0] data);
		logic [3:0] nib[4];
		logic [3:0] seen;
		int         e;
		int         n;
		e = errors;
		nib[0] = {1'b0, dev[6:4]};
		nib[1] = dev[3:0];
		nib[2] = data[7:4];
		nib[3] = data[3:0];
		seen = 4'b0000;
		n = 0;
		while (seen != 4'b1111) begin
			@(negedge clk1);
			for (int d = 0; d < 4; d++) begin
				if (anode == ~(4'b0001 << d)) begin
					seen[d] = 1'b1;
					check_val($sformatf("cathode digit %0d", d), cathode, seg_pattern(nib[d]));
				end
			end
			if (++n > 8 * SCAN_DIV) begin
				$display("Seven-segment scan did not show all four digits");
				errors++;
				break;
			end
		end
		report_test("seven segment", e);
	endtask

	initial begin
		logic [7:0] wbyte;
		seed         = 74;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		lcd_head     = 0;
		reset   <= 1'b1;
		awaddr  <= '0;
		awvalid <= 1'b0;
		wdata   <= '0;
		wstrb   <= '0;
		wvalid  <= 1'b0;
		bready  <= 1'b0;
		araddr  <= '0;
		arvalid <= 1'b0;
		rready  <= 1'b0;
		repeat (3) @(posedge clk1);
		reset <= 1'b0;

		test_lcd_init();
		test_registers();
		test_write(wbyte);
		test_read(wbyte);
		test_nack(wbyte, ~wbyte);
		test_segments(7'h23, ~wbyte);

		$display("tests run %0d, tests failed %0d, failed checks %0d",
		         tests_run, tests_failed, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

/* eeprom_panel.f */
rtl/i2c_pkg.sv
rtl/display_pkg.sv
rtl/axil_ctrl_regs.sv
rtl/i2c_byte_master.sv
rtl/seg_scanner.sv
rtl/lcd_status_writer.sv
rtl/eeprom_panel_top.sv
verif/i2c_eeprom_model.sv
verif/eeprom_panel_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f eeprom_panel.f \
	--top-module eeprom_panel_tb -o eeprom_panel_sim

./obj_dir/eeprom_panel_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failures found" sim.log; then
	exit 1
fi
exit 0
